//--- dv/tx_trace.txt
# test  active  wqes_per_qp  sq_base   psn_base  stall_pct
# active, sq_base and psn_base are hex, the rest decimal
# single qp, descriptors in order
1       01      5            80000000  000100    0
# same qp run past the end of its send queue
2       01      20           80000000  000200    10
# several qps interleaved, psn wraps on qp0
3       a5      3            80000000  fffffe    20
# all qps, new base
4       ff      2            10000000  001000    50
# heavy descriptor stalls fill the cache
5       3c      4            80000000  123456    90
# wrap on the last qp
6       80      18           00000000  000010    30
# heavy stalls over alternating qps
7       55      6            10000000  00abcd    95
# two qps, no stalls
8       12      3            80000000  7ffffe    0
# everything again after the wraps
9       ff      3            80000000  000300    40

//--- all.f
hdl/rdma_cfg_pkg.sv
hdl/ib_hdr_pkg.sv
hdl/wqe_sched.sv
hdl/wqe_fetch.sv
hdl/wqe_cache.sv
hdl/ib_transport.sv
hdl/tx_engine.sv
dv/tx_engine_properties.sv
dv/tb_tx_engine.sv

//--- dv/tb_tx_engine.sv
`default_nettype none
`timescale 1ns/1ps

module tb_tx_engine;

    import rdma_cfg_pkg::*;
    import ib_hdr_pkg::*;

    logic      i_clk;
    logic      i_arst_n;
    qp_mask_t  i_active;
    axi_addr_t i_sq_base;
    rnic_ctx_t i_rnic;
    axi_addr_t o_axi_araddr;
    logic      o_axi_arvalid;
    logic      i_axi_arready;
    wqe_data_t i_axi_rdata;
    logic      i_axi_rvalid;
    logic      o_axi_rready;
    logic      o_qpc_lookup_valid;
    logic      i_qpc_lookup_ready;
    qp_id_t    o_qpc_lookup_qp;
    logic      i_qpc_valid;
    qpc_ctx_t  i_qpc;
    logic      o_qpc_update_valid;
    qp_id_t    o_qpc_update_qp;
    psn_t      o_qpc_psn;
    msn_t      o_qpc_msn;
    logic      o_pkt_desc_valid;
    logic      i_pkt_desc_ready;
    pkt_desc_t o_pkt_desc;
    qp_id_t    o_qpn;

    logic [31:0] lfsr;
    int          err_total;
    int          err_test;
    int          ar_count;
    int          desc_count;
    int          stall_pct;
    axi_addr_t   base_v;
    int          rem_ar [MAX_QP];
    int          sq_idx_m [MAX_QP];
    psn_t        psn_m [MAX_QP];
    msn_t        msn_m [MAX_QP];
    axi_addr_t   ar_q [$];
    axi_addr_t   dq_addr [$];
    qp_id_t      dq_qp [$];
    logic        mem_busy;
    int          mem_wait;
    axi_addr_t   mem_addr;
    logic        ctx_busy;
    int          ctx_wait;
    qp_id_t      ctx_qp;

    tx_engine i_tx_engine (.*);

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic mac_t mac_for_qp(input qp_id_t q);
        return {40'h02_00_5e_00_00, 5'b0, q};
    endfunction

    task automatic check_value(input string name, input logic [279:0] got,
                               input logic [279:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, exp);
            err_total++;
            err_test++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("%0t: %s", $time, what);
        err_total++;
        err_test++;
    endtask

    // host memory, context store and descriptor sink
    always @(posedge i_clk) begin : models
        pkt_desc_t exp_d;
        qp_id_t    q;
        axi_addr_t a;
        if (o_axi_arvalid && i_axi_arready) begin
            if (ar_q.size() == 0) begin
                flag_error("AXI read issued with no WQE left to fetch");
            end else begin
                check_value("o_axi_araddr", o_axi_araddr, ar_q.pop_front());
            end
            q = qp_id_t'((o_axi_araddr - base_v) / 256);
            if (rem_ar[q] > 0) begin
                rem_ar[q]--;
            end
            ar_count++;
            mem_busy = 1'b1;
            mem_wait = rand_bits(2);
            mem_addr = o_axi_araddr;
        end
        if (i_axi_rvalid && o_axi_rready) begin
            mem_busy = 1'b0;
        end
        if (o_qpc_lookup_valid && i_qpc_lookup_ready) begin
            if (dq_qp.size() > 0) begin
                check_value("o_qpc_lookup_qp", o_qpc_lookup_qp, dq_qp[0]);
            end
            ctx_busy = 1'b1;
            ctx_wait = rand_bits(2);
            ctx_qp   = o_qpc_lookup_qp;
        end
        if (o_pkt_desc_valid && i_pkt_desc_ready) begin
            if (dq_qp.size() == 0) begin
                flag_error("descriptor accepted with no WQE outstanding");
            end else begin
                q = dq_qp.pop_front();
                a = dq_addr.pop_front();
                exp_d.dest_mac  = mac_for_qp(q);
                exp_d.src_mac   = i_rnic.src_mac;
                exp_d.src_port  = i_rnic.src_port;
                exp_d.pkey      = 16'hffff;
                exp_d.dest_qpid = 24'h100 + q;
                exp_d.psn       = psn_m[q];
                exp_d.opcode    = a[4] ? 8'h0a : 8'h04;
                exp_d.length    = {16'h0, a[15:0]};
                exp_d.wr_id     = {32'h0, a};
                check_value("o_qpn", o_qpn, q);
                check_value("o_pkt_desc", o_pkt_desc, exp_d);
                check_value("o_qpc_update_valid", o_qpc_update_valid, 1'b1);
                check_value("o_qpc_update_qp", o_qpc_update_qp, q);
                check_value("o_qpc_psn", o_qpc_psn, psn_t'(psn_m[q] + 1'b1));
                check_value("o_qpc_msn", o_qpc_msn, msn_t'(msn_m[q] + 1'b1));
                psn_m[q] = psn_m[q] + 1'b1;
                msn_m[q] = msn_m[q] + 1'b1;
            end
            desc_count++;
        end else if (o_qpc_update_valid) begin
            flag_error("context update pulse without a descriptor handshake");
        end
        if (ar_count - desc_count > CACHE_DEPTH + 1) begin
            flag_error("more WQE reads in flight than the cache can absorb");
        end
        #1;
        for (int i = 0; i < MAX_QP; i++) begin
            i_active[i] = (rem_ar[i] > 0);
        end
        i_sq_base     = base_v;
        i_axi_arready = rand_bits(1) | rand_bits(1);
        if (!mem_busy) begin
            i_axi_rvalid = 1'b0;
        end else if (!i_axi_rvalid) begin
            if (mem_wait == 0) begin
                i_axi_rvalid = 1'b1;
                i_axi_rdata  = {32'h0, mem_addr, 16'h0, mem_addr[15:0], 7'h0, mem_addr[4],
                                24'h0};
            end else begin
                mem_wait--;
            end
        end
        i_qpc_valid = 1'b0;
        if (ctx_busy) begin
            if (ctx_wait == 0) begin
                i_qpc_valid     = 1'b1;
                i_qpc.pkey      = 16'hffff;
                i_qpc.dest_qpid = 24'h100 + ctx_qp;
                i_qpc.psn       = psn_m[ctx_qp];
                i_qpc.msn       = msn_m[ctx_qp];
                i_qpc.dest_mac  = mac_for_qp(ctx_qp);
                ctx_busy        = 1'b0;
            end else begin
                ctx_wait--;
            end
        end
        i_qpc_lookup_ready = rand_bits(1) | rand_bits(1);
        i_pkt_desc_ready   = ((rand_bits(7) * 100) >> 7) >= stall_pct;
    end

    initial begin : main
        int        fd;
        string     line;
        int        n_fields;
        int        tnum;
        qp_mask_t  mask;
        int        per_qp;
        axi_addr_t base;
        psn_t      psn_base;
        int        stall;
        int        rem [MAX_QP];
        int        total;
        int        last_qp;
        int        q;
        int        start;
        int        cycles;
        int        tests;
        logic      stop;
        i_clk              = 1'b0;
        i_arst_n           = 1'b1;
        i_active           = '0;
        i_sq_base          = '0;
        i_rnic.src_mac     = 48'h02_11_22_33_44_55;
        i_rnic.src_port    = 16'hc000;
        i_axi_arready      = 1'b0;
        i_axi_rdata        = '0;
        i_axi_rvalid       = 1'b0;
        i_qpc_lookup_ready = 1'b0;
        i_qpc_valid        = 1'b0;
        i_qpc              = '0;
        i_pkt_desc_ready   = 1'b0;
        lfsr       = 32'hf8fc_d2cb;
        err_total  = 0;
        err_test   = 0;
        ar_count   = 0;
        desc_count = 0;
        stall_pct  = 0;
        base_v     = '0;
        mem_busy   = 1'b0;
        ctx_busy   = 1'b0;
        tests      = 0;
        stop       = 1'b0;
        // dut resets to the last qp so the first grant goes to qp0
        last_qp    = MAX_QP - 1;
        for (int i = 0; i < MAX_QP; i++) begin
            rem_ar[i]   = 0;
            sq_idx_m[i] = 0;
        end
        fd = $fopen("dv/tx_trace.txt", "r");
        if (fd == 0) begin
            flag_error("cannot open dv/tx_trace.txt");
        end
        #1 i_arst_n = 1'b0;
        repeat (4) @(posedge i_clk);
        #1 i_arst_n = 1'b1;

        while (!stop && fd != 0 && $fgets(line, fd) != 0) begin
            n_fields = $sscanf(line, "%d %h %d %h %h %d",
                               tnum, mask, per_qp, base, psn_base, stall);
            if (line.len() == 0 || line[0] == "#" || n_fields != 6) begin
                continue;
            end
            @(negedge i_clk);
            err_test = 0;
            total    = 0;
            for (int i = 0; i < MAX_QP; i++) begin
                rem[i]    = mask[i] ? per_qp : 0;
                rem_ar[i] = rem[i];
                total    += rem[i];
                psn_m[i]  = psn_base + psn_t'(i << 12);
                msn_m[i]  = msn_t'(i * 16);
            end
            // expected grant order is round robin over the qps with work left
            for (int k = 0; k < total; k++) begin
                q = (last_qp + 1) % MAX_QP;
                while (rem[q] == 0) begin
                    q = (q + 1) % MAX_QP;
                end
                rem[q]--;
                ar_q.push_back(axi_addr_t'(base + q * 256 + sq_idx_m[q] * 16));
                dq_addr.push_back(ar_q[$]);
                dq_qp.push_back(qp_id_t'(q));
                sq_idx_m[q] = (sq_idx_m[q] + 1) % 16;
                last_qp = q;
            end
            base_v    = base;
            stall_pct = stall;
            start     = desc_count;
            cycles    = 0;
            while (desc_count - start < total && cycles < 300 + total * 200) begin
                @(negedge i_clk);
                cycles++;
            end
            if (desc_count - start < total) begin
                flag_error("timeout waiting for descriptors");
                stop = 1'b1;
            end else if (ar_q.size() != 0 || dq_qp.size() != 0) begin
                flag_error("WQEs still expected after the last descriptor");
            end
            $display("case %0d: mask %02h, %0d per qp, stall %0d%%, %0d descriptors, %0d errors",
                     tnum, mask, per_qp, stall, desc_count - start, err_test);
            tests++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests == 0) begin
            flag_error("no test lines found in the trace");
        end
        if (i_tx_engine.u_tx_engine_properties.fail_cnt != 0) begin
            flag_error("bound assertions on tx_engine failed");
        end
        $display("summary: %0d tests, %0d descriptors, %0d errors",
                 tests, desc_count, err_total);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tx_engine_properties.sv
`default_nettype none
`timescale 1ns/1ps

module tx_engine_properties (
    input wire                          i_clk,
    input wire                          i_arst_n,
    input wire                          o_axi_arvalid,
    input wire                          i_axi_arready,
    input wire rdma_cfg_pkg::axi_addr_t o_axi_araddr,
    input wire                          o_axi_rready,
    input wire                          o_qpc_lookup_valid,
    input wire                          o_pkt_desc_valid,
    input wire                          i_pkt_desc_ready,
    input wire ib_hdr_pkg::pkt_desc_t   o_pkt_desc,
    input wire                          o_qpc_update_valid
);

    // assertion failures so far
    int fail_cnt = 0;

    ar_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_axi_arvalid && !i_axi_arready |=> o_axi_arvalid && $stable(o_axi_araddr))
        else begin
            $error("arvalid dropped or araddr moved before arready");
            fail_cnt++;
        end

    desc_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pkt_desc_valid && !i_pkt_desc_ready |=> o_pkt_desc_valid && $stable(o_pkt_desc))
        else begin
            $error("descriptor dropped or changed before ready");
            fail_cnt++;
        end

    // update is tied to descriptor acceptance
    update_on_hs: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_qpc_update_valid |-> o_pkt_desc_valid && i_pkt_desc_ready)
        else begin
            $error("context update outside a descriptor handshake");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge i_clk)
        !i_arst_n |-> !(o_axi_arvalid || o_axi_rready || o_qpc_lookup_valid
                        || o_pkt_desc_valid || o_qpc_update_valid))
        else begin
            $error("control output high during reset");
            fail_cnt++;
        end

endmodule

bind tx_engine tx_engine_properties u_tx_engine_properties (.*);

`default_nettype wire

//--- hdl/tx_engine.sv
`default_nettype none
`timescale 1ns/1ps

module tx_engine (
    input  wire                           i_clk,
    input  wire                           i_arst_n,
    input  wire rdma_cfg_pkg::qp_mask_t   i_active,
    input  wire rdma_cfg_pkg::axi_addr_t  i_sq_base,
    input  wire ib_hdr_pkg::rnic_ctx_t    i_rnic,
    // axi read channel
    output rdma_cfg_pkg::axi_addr_t       o_axi_araddr,
    output logic                          o_axi_arvalid,
    input  wire                           i_axi_arready,
    input  wire rdma_cfg_pkg::wqe_data_t  i_axi_rdata,
    input  wire                           i_axi_rvalid,
    output logic                          o_axi_rready,
    // qp context lookup and update
    output logic                          o_qpc_lookup_valid,
    input  wire                           i_qpc_lookup_ready,
    output rdma_cfg_pkg::qp_id_t          o_qpc_lookup_qp,
    input  wire                           i_qpc_valid,
    input  wire ib_hdr_pkg::qpc_ctx_t     i_qpc,
    output logic                          o_qpc_update_valid,
    output rdma_cfg_pkg::qp_id_t          o_qpc_update_qp,
    output ib_hdr_pkg::psn_t              o_qpc_psn,
    output ib_hdr_pkg::msn_t              o_qpc_msn,
    // packet descriptor
    output logic                          o_pkt_desc_valid,
    input  wire                           i_pkt_desc_ready,
    output ib_hdr_pkg::pkt_desc_t         o_pkt_desc,
    output rdma_cfg_pkg::qp_id_t          o_qpn
);

    import rdma_cfg_pkg::*;
    import ib_hdr_pkg::*;

    logic         sched_val;
    qp_id_t       sched_qp;
    logic         fetch_ready;
    logic         cache_wr;
    cache_entry_t cache_wr_entry;
    logic         cache_alfull;
    logic         cache_empty;
    logic         cache_rd;
    cache_entry_t cache_head;

    wqe_sched u_wqe_sched (
        .i_clk          ( i_clk          ),
        .i_arst_n       ( i_arst_n       ),
        .i_active       ( i_active       ),
        .i_fetch_ready  ( fetch_ready    ),
        .i_cache_alfull ( cache_alfull   ),
        .o_sched_val    ( sched_val      ),
        .o_sched_qp     ( sched_qp       )
    );

    wqe_fetch u_wqe_fetch (
        .i_clk          ( i_clk          ),
        .i_arst_n       ( i_arst_n       ),
        .i_sched_val    ( sched_val      ),
        .i_sched_qp     ( sched_qp       ),
        .i_sq_base      ( i_sq_base      ),
        .o_fetch_ready  ( fetch_ready    ),
        .o_axi_araddr   ( o_axi_araddr   ),
        .o_axi_arvalid  ( o_axi_arvalid  ),
        .i_axi_arready  ( i_axi_arready  ),
        .i_axi_rdata    ( i_axi_rdata    ),
        .i_axi_rvalid   ( i_axi_rvalid   ),
        .o_axi_rready   ( o_axi_rready   ),
        .o_cache_wr     ( cache_wr       ),
        .o_cache_entry  ( cache_wr_entry )
    );

    wqe_cache u_wqe_cache (
        .i_clk          ( i_clk          ),
        .i_arst_n       ( i_arst_n       ),
        .i_wr           ( cache_wr       ),
        .i_entry        ( cache_wr_entry ),
        .o_alfull       ( cache_alfull   ),
        .o_empty        ( cache_empty    ),
        .i_rd           ( cache_rd       ),
        .o_head         ( cache_head     )
    );

    ib_transport u_ib_transport (
        .i_clk              ( i_clk              ),
        .i_arst_n           ( i_arst_n           ),
        .i_cache_empty      ( cache_empty        ),
        .i_head             ( cache_head         ),
        .o_cache_rd         ( cache_rd           ),
        .i_rnic             ( i_rnic             ),
        .o_qpc_lookup_valid ( o_qpc_lookup_valid ),
        .i_qpc_lookup_ready ( i_qpc_lookup_ready ),
        .o_qpc_lookup_qp    ( o_qpc_lookup_qp    ),
        .i_qpc_valid        ( i_qpc_valid        ),
        .i_qpc              ( i_qpc              ),
        .o_qpc_update_valid ( o_qpc_update_valid ),
        .o_qpc_update_qp    ( o_qpc_update_qp    ),
        .o_qpc_psn          ( o_qpc_psn          ),
        .o_qpc_msn          ( o_qpc_msn          ),
        .o_pkt_desc_valid   ( o_pkt_desc_valid   ),
        .i_pkt_desc_ready   ( i_pkt_desc_ready   ),
        .o_pkt_desc         ( o_pkt_desc         ),
        .o_qpn              ( o_qpn              )
    );

endmodule

`default_nettype wire

//--- hdl/ib_transport.sv
`default_nettype none
`timescale 1ns/1ps

module ib_transport (
    input  wire                           i_clk,
    input  wire                           i_arst_n,
    // wqe cache
    input  wire                           i_cache_empty,
    input  wire ib_hdr_pkg::cache_entry_t i_head,
    output logic                          o_cache_rd,
    input  wire ib_hdr_pkg::rnic_ctx_t    i_rnic,
    // context lookup
    output logic                          o_qpc_lookup_valid,
    input  wire                           i_qpc_lookup_ready,
    output rdma_cfg_pkg::qp_id_t          o_qpc_lookup_qp,
    input  wire                           i_qpc_valid,
    input  wire ib_hdr_pkg::qpc_ctx_t     i_qpc,
    // context update
    output logic                          o_qpc_update_valid,
    output rdma_cfg_pkg::qp_id_t          o_qpc_update_qp,
    output ib_hdr_pkg::psn_t              o_qpc_psn,
    output ib_hdr_pkg::msn_t              o_qpc_msn,
    // packet descriptor
    output logic                          o_pkt_desc_valid,
    input  wire                           i_pkt_desc_ready,
    output ib_hdr_pkg::pkt_desc_t         o_pkt_desc,
    output rdma_cfg_pkg::qp_id_t          o_qpn
);

    import ib_hdr_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WAIT_CTX,
        S_DESC
    } state_t;

    state_t       state;
    cache_entry_t entry_q;
    qpc_ctx_t     ctx_q;
    ib_opcode_t   opcode;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!i_cache_empty) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (i_qpc_lookup_ready) begin
                        state <= S_WAIT_CTX;
                    end
                end
                S_WAIT_CTX: begin
                    if (i_qpc_valid) begin
                        state <= S_DESC;
                    end
                end
                S_DESC: begin
                    if (i_pkt_desc_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_cache_rd) begin
            entry_q <= i_head;
        end
        if ((state == S_WAIT_CTX) && i_qpc_valid) begin
            ctx_q <= i_qpc;
        end
    end

    // pop as we leave idle, entry is latched on the same edge
    assign o_cache_rd = (state == S_IDLE) && !i_cache_empty;

    assign o_qpc_lookup_valid = (state == S_LOOKUP);
    assign o_qpc_lookup_qp    = entry_q.qp;

    always_comb begin
        case (entry_q.wqe.kind)
            8'h01:   opcode = OP_WRITE_ONLY;
            default: opcode = OP_SEND_ONLY;
        endcase
    end

    always_comb begin
        o_pkt_desc.dest_mac  = ctx_q.dest_mac;
        o_pkt_desc.src_mac   = i_rnic.src_mac;
        o_pkt_desc.src_port  = i_rnic.src_port;
        o_pkt_desc.pkey      = ctx_q.pkey;
        o_pkt_desc.dest_qpid = ctx_q.dest_qpid;
        o_pkt_desc.psn       = ctx_q.psn;
        o_pkt_desc.opcode    = opcode;
        o_pkt_desc.length    = entry_q.wqe.length;
        o_pkt_desc.wr_id     = entry_q.wqe.wr_id;
    end

    assign o_pkt_desc_valid = (state == S_DESC);
    assign o_qpn            = entry_q.qp;

    // one packet per wqe, so psn and msn both step by one
    assign o_qpc_update_valid = o_pkt_desc_valid && i_pkt_desc_ready;
    assign o_qpc_update_qp    = entry_q.qp;
    assign o_qpc_psn          = psn_t'(ctx_q.psn + 1'b1);
    assign o_qpc_msn          = msn_t'(ctx_q.msn + 1'b1);

endmodule

`default_nettype wire

//--- hdl/wqe_cache.sv
`default_nettype none
`timescale 1ns/1ps

module wqe_cache (
    input  wire                           i_clk,
    input  wire                           i_arst_n,
    input  wire                           i_wr,
    input  wire ib_hdr_pkg::cache_entry_t i_entry,
    output logic                          o_alfull,
    output logic                          o_empty,
    input  wire                           i_rd,
    output ib_hdr_pkg::cache_entry_t      o_head
);

    import rdma_cfg_pkg::*;
    import ib_hdr_pkg::*;

    typedef logic [$clog2(CACHE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(CACHE_DEPTH+1)-1:0] cnt_t;

    cache_entry_t mem [CACHE_DEPTH];
    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    cnt_t         count;
    logic         do_wr;
    logic         do_rd;

    assign do_wr = i_wr && (count != cnt_t'(CACHE_DEPTH));
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_entry;
        end
    end

    // one slot kept back for the read still in flight
    assign o_alfull = (count >= cnt_t'(CACHE_DEPTH - 1));
    assign o_empty  = (count == '0);
    assign o_head   = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/wqe_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module wqe_fetch (
    input  wire                          i_clk,
    input  wire                          i_arst_n,
    input  wire                          i_sched_val,
    input  wire rdma_cfg_pkg::qp_id_t    i_sched_qp,
    input  wire rdma_cfg_pkg::axi_addr_t i_sq_base,
    output logic                         o_fetch_ready,
    // axi read address
    output rdma_cfg_pkg::axi_addr_t      o_axi_araddr,
    output logic                         o_axi_arvalid,
    input  wire                          i_axi_arready,
    // axi read data, single beat
    input  wire rdma_cfg_pkg::wqe_data_t i_axi_rdata,
    input  wire                          i_axi_rvalid,
    output logic                         o_axi_rready,
    // to wqe cache
    output logic                         o_cache_wr,
    output ib_hdr_pkg::cache_entry_t     o_cache_entry
);

    import rdma_cfg_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_t;

    state_t  state;
    qp_id_t  cur_qp;
    sq_idx_t sq_idx [MAX_QP];
    logic    r_beat;

    assign r_beat = (state == S_DATA) && i_axi_rvalid;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= S_IDLE;
            for (int q = 0; q < MAX_QP; q++) begin
                sq_idx[q] <= '0;
            end
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_sched_val) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (i_axi_arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (i_axi_rvalid) begin
                        state <= S_IDLE;
                        if (sq_idx[cur_qp] == sq_idx_t'(SQ_DEPTH - 1)) begin
                            sq_idx[cur_qp] <= '0;
                        end else begin
                            sq_idx[cur_qp] <= sq_idx[cur_qp] + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // address is fixed at grant time and held through the handshake
    always_ff @(posedge i_clk) begin
        if ((state == S_IDLE) && i_sched_val) begin
            cur_qp       <= i_sched_qp;
            o_axi_araddr <= i_sq_base
                          + axi_addr_t'(i_sched_qp) * SQ_BYTES
                          + axi_addr_t'(sq_idx[i_sched_qp]) * WQE_BYTES;
        end
    end

    // low on the grant cycle itself so no second grant slips in
    assign o_fetch_ready = (state == S_IDLE) && !i_sched_val;

    assign o_axi_arvalid = (state == S_ADDR);
    assign o_axi_rready  = (state == S_DATA);

    assign o_cache_wr        = r_beat;
    assign o_cache_entry.qp  = cur_qp;
    assign o_cache_entry.wqe = i_axi_rdata;

endmodule

`default_nettype wire

//--- hdl/wqe_sched.sv
`default_nettype none
`timescale 1ns/1ps

module wqe_sched (
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire rdma_cfg_pkg::qp_mask_t i_active,
    input  wire                       i_fetch_ready,
    input  wire                       i_cache_alfull,
    output logic                      o_sched_val,
    output rdma_cfg_pkg::qp_id_t      o_sched_qp
);

    import rdma_cfg_pkg::*;

    qp_id_t last_qp;
    qp_id_t next_qp;
    qp_id_t cand;
    logic   go;

    // rotating priority, nearest active qp after the last grant wins
    always_comb begin
        next_qp = last_qp;
        cand    = last_qp;
        for (int i = MAX_QP; i >= 1; i--) begin
            cand = qp_id_t'(last_qp + i);
            if (i_active[cand]) begin
                next_qp = cand;
            end
        end
    end

    assign go = i_fetch_ready && !i_cache_alfull && (|i_active);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_sched_val <= 1'b0;
            // so the first search starts at qp0
            last_qp     <= qp_id_t'(MAX_QP - 1);
        end else begin
            o_sched_val <= go;
            if (go) begin
                last_qp <= next_qp;
            end
        end
    end

    // last grant doubles as the pulse payload
    assign o_sched_qp = last_qp;

endmodule

`default_nettype wire

//--- hdl/ib_hdr_pkg.sv
`default_nettype none

package ib_hdr_pkg;

    typedef logic [23:0] psn_t;
    typedef logic [23:0] msn_t;
    typedef logic [23:0] ib_qpn_t;
    typedef logic [15:0] pkey_t;
    typedef logic [47:0] mac_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [63:0] wr_id_t;
    typedef logic [7:0]  ib_opcode_t;

    // bth opcodes, rc only
    localparam ib_opcode_t OP_SEND_ONLY  = 8'h04;
    localparam ib_opcode_t OP_WRITE_ONLY = 8'h0A;

    // kind 0 is send, 1 is rdma write
    typedef struct packed {
        wr_id_t      wr_id;
        logic [31:0] length;
        logic [7:0]  kind;
        logic [23:0] rsvd;
    } wqe_t;

    typedef struct packed {
        rdma_cfg_pkg::qp_id_t qp;
        wqe_t                 wqe;
    } cache_entry_t;

    typedef struct packed {
        pkey_t   pkey;
        ib_qpn_t dest_qpid;
        psn_t    psn;
        msn_t    msn;
        mac_t    dest_mac;
    } qpc_ctx_t;

    // per-function constants, static after init
    typedef struct packed {
        mac_t      src_mac;
        udp_port_t src_port;
    } rnic_ctx_t;

    typedef struct packed {
        mac_t        dest_mac;
        mac_t        src_mac;
        udp_port_t   src_port;
        pkey_t       pkey;
        ib_qpn_t     dest_qpid;
        psn_t        psn;
        ib_opcode_t  opcode;
        logic [31:0] length;
        wr_id_t      wr_id;
    } pkt_desc_t;

endpackage

`default_nettype wire

//--- hdl/rdma_cfg_pkg.sv
`default_nettype none

package rdma_cfg_pkg;

    // queue pair population
    localparam int MAX_QP      = 8;
    localparam int QP_PTR_W    = 3;

    // send queue geometry
    localparam int SQ_DEPTH    = 16;
    localparam int SQ_PTR_W    = 4;
    localparam int WQE_W       = 128;
    localparam int WQE_BYTES   = WQE_W / 8;
    localparam int SQ_BYTES    = SQ_DEPTH * WQE_BYTES;

    // host read port
    localparam int AXI_ADDR_W  = 32;

    // on-chip wqe buffering
    localparam int CACHE_DEPTH = 4;

    typedef logic [QP_PTR_W-1:0]   qp_id_t;
    typedef logic [MAX_QP-1:0]     qp_mask_t;
    typedef logic [SQ_PTR_W-1:0]   sq_idx_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    // raw beat as it comes off the read channel
    typedef logic [WQE_W-1:0]      wqe_data_t;

endpackage

`default_nettype wire
